// ==== hw/psg_host_regs.sv ====
////////////////////
// host write slave with N, mode and DA registers
// also turns DA into the 9-bit two's complement PCM word
////////////////////

module psg_host_regs (
  input  logic                            CLK,
  input  logic                            arst_n,
  input  logic                            wr_req,
  input  logic [psg_pkg::WR_ADDR_W-1:0]   wr_addr,
  input  logic [psg_pkg::WR_DATA_W-1:0]   wr_data,
  output logic                            wr_ack,
  psg_ctrl_if.regs                        ctrl,
  output logic [psg_pkg::PCM_W-1:0]       pcm_out
);

  logic [psg_pkg::N_W-1:0]       n_reg;
  logic [psg_pkg::MODE_W-1:0]    mode_reg;
  logic [psg_pkg::WR_DATA_W-1:0] da_reg;
  logic [psg_pkg::PCM_W-2:0]     sample;

  ////////////////////
  // four-phase write slave
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ack   <= 1'b0;
      n_reg    <= '0;
      mode_reg <= '0;
      da_reg   <= '0;
    end else if (wr_req && !wr_ack) begin
      wr_ack <= 1'b1;            // data lands on this same edge
      case (wr_addr)
        psg_pkg::ADDR_N:    n_reg    <= wr_data[psg_pkg::N_W-1:0];
        psg_pkg::ADDR_MODE: mode_reg <= wr_data[psg_pkg::MODE_W-1:0];
        psg_pkg::ADDR_DA:   da_reg   <= wr_data;
        default: ;               // address 3 is a no-op
      endcase
    end else if (!wr_req) begin
      wr_ack <= 1'b0;
    end
  end

  assign ctrl.n_reload = n_reg;
  assign ctrl.tone_ie  = mode_reg[psg_pkg::MODE_TONE_IE];
  assign ctrl.ns_ie    = mode_reg[psg_pkg::MODE_NS_IE];
  assign ctrl.nss      = mode_reg[psg_pkg::MODE_NSS];
  assign ctrl.time_ie  = mode_reg[psg_pkg::MODE_TIME_IE];
  assign ctrl.ns_rate  = mode_reg[psg_pkg::MODE_NS_RATE_HI:psg_pkg::MODE_NS_RATE_LO];

  ////////////////////
  // DAC conversion
  // bit 9 inverts the raw sample, bit 8 is the sign
  assign sample  = da_reg[9] ? ~da_reg[7:0] : da_reg[7:0];
  assign pcm_out = {da_reg[8], da_reg[8] ? ~sample : sample};

  // ack only ever answers a request seen on the previous edge
  a_ack_needs_req : assert property (
    @(posedge CLK) disable iff (!arst_n) $rose(wr_ack) |-> $past(wr_req)
  );

endmodule

// ==== hw/psg_ifs.sv ====
////////////////////
// control and event bundles passed between the sound timer units
////////////////////

// host register contents, fanned out to every unit
interface psg_ctrl_if;
  logic [psg_pkg::N_W-1:0] n_reload;
  logic                    tone_ie;
  logic                    ns_ie;
  logic                    nss;
  logic                    time_ie;
  logic [1:0]              ns_rate;

  modport regs (
    output n_reload, tone_ie, ns_ie, nss, time_ie, ns_rate
  );
  modport user (
    input n_reload, tone_ie, ns_ie, nss, time_ie, ns_rate
  );
endinterface

// one-CLK event pulses, all aligned to a tick cycle
interface psg_evt_if;
  logic                  tick;
  logic                  time_evt;
  logic                  ns_evt;
  logic                  tone_evt;
  psg_pkg::tone_range_e  tone_range;

  modport time_src (output tick, time_evt, ns_evt);
  modport tone_src (input tick, output tone_evt, tone_range);
  modport sink (
    input tick, time_evt, ns_evt, tone_evt, tone_range
  );
endinterface

// ==== hw/psg_int_ctrl.sv ====
////////////////////
// fixed-priority interrupt controller with four-phase req/ack
// serves tone, NS and time events and latches the vector
////////////////////

module psg_int_ctrl (
  input  logic                      CLK,
  input  logic                      arst_n,
  psg_ctrl_if.user                  ctrl,
  psg_evt_if.sink                   evt,
  output logic                      int_req,
  input  logic                      int_ack,
  output logic [psg_pkg::VEC_W-1:0] int_vec
);

  localparam int NUM_IRQ = 3;

  logic [NUM_IRQ-1:0]        set_pend;
  logic [NUM_IRQ-1:0]        pend;
  logic [NUM_IRQ-1:0]        active;
  logic [NUM_IRQ-1:0]        grant;
  logic [psg_pkg::VEC_W-1:0] tone_ofs;
  logic [psg_pkg::VEC_W-1:0] vec_nxt;

  assign set_pend[psg_pkg::IRQ_TONE] = evt.tone_evt & ctrl.tone_ie;
  assign set_pend[psg_pkg::IRQ_NS]   = evt.ns_evt & ctrl.ns_ie;
  assign set_pend[psg_pkg::IRQ_TIME] = evt.time_evt & ctrl.time_ie;

  ////////////////////
  // priority pick
  always_comb begin
    grant = '0;
    if (active == '0 && !int_ack) begin
      if (pend[psg_pkg::IRQ_TONE])      grant[psg_pkg::IRQ_TONE] = 1'b1;
      else if (pend[psg_pkg::IRQ_NS])   grant[psg_pkg::IRQ_NS]   = 1'b1;
      else if (pend[psg_pkg::IRQ_TIME]) grant[psg_pkg::IRQ_TIME] = 1'b1;
    end
  end

  always_comb begin
    case (evt.tone_range)
      psg_pkg::RANGE_10_1F: tone_ofs = psg_pkg::VEC_OFS_10_1F;
      psg_pkg::RANGE_20_3F: tone_ofs = psg_pkg::VEC_OFS_20_3F;
      psg_pkg::RANGE_40_FF: tone_ofs = psg_pkg::VEC_OFS_40_FF;
      default:              tone_ofs = '0;
    endcase
  end

  always_comb begin
    if (grant[psg_pkg::IRQ_TONE])    vec_nxt = psg_pkg::VEC_TONE_BASE | tone_ofs;
    else if (grant[psg_pkg::IRQ_NS]) vec_nxt = psg_pkg::VEC_NS;
    else                             vec_nxt = psg_pkg::VEC_TIME;
  end

  ////////////////////
  // pending and active state
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pend    <= '0;
      active  <= '0;
      int_vec <= '0;
    end else begin
      // the active source swallows its own new events
      pend   <= (pend | (set_pend & ~active)) & ~grant;
      active <= int_ack ? '0 : (active | grant);
      if (|grant)
        int_vec <= vec_nxt;      // tone offset frozen here
    end
  end

  assign int_req = |active;

  a_one_active : assert property (
    @(posedge CLK) disable iff (!arst_n) $onehot0(active)
  );

  // host handshake must complete before the next request
  a_no_req_in_ack : assert property (
    @(posedge CLK) disable iff (!arst_n) $rose(int_req) |-> !$past(int_ack)
  );

endmodule

// ==== hw/psg_noise_lfsr.sv ====
////////////////////
// PNC1/PNC2 noise shift registers, stepped once per NS event
////////////////////

module psg_noise_lfsr (
  input  logic                       CLK,
  input  logic                       arst_n,
  psg_ctrl_if.user                   ctrl,
  input  logic                       ns_evt,
  output logic [psg_pkg::PNC1_W-1:0] pnc_out,
  output logic                       noise_sign
);

  logic [psg_pkg::PNC1_W-1:0] pnc1;
  logic [2:0]                 pnc2;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pnc1 <= '0;
      pnc2 <= '0;
    end else if (ns_evt) begin
      pnc1 <= {pnc1[5:0], ~(pnc1[5] ^ pnc1[6])};
      // nss set gives a plain toggle chain
      pnc2 <= {pnc2[1:0], ~(ctrl.nss ? pnc2[0] : (pnc2[1] ^ noise_sign))};
    end
  end

  assign pnc_out    = pnc1;
  assign noise_sign = ctrl.nss & pnc2[2];   // drops at once when nss clears

endmodule

// ==== hw/psg_pkg.sv ====
////////////////////
// register map, widths and interrupt codes shared by all sound timer units
////////////////////

package psg_pkg;

  // host write port
  localparam int WR_ADDR_W = 2;
  localparam int WR_DATA_W = 10;           // also the DA register width

  localparam logic [WR_ADDR_W-1:0] ADDR_N    = 2'd0;
  localparam logic [WR_ADDR_W-1:0] ADDR_MODE = 2'd1;
  localparam logic [WR_ADDR_W-1:0] ADDR_DA   = 2'd2;

  localparam int N_W    = 8;
  localparam int PCM_W  = 9;
  localparam int PNC1_W = 7;
  localparam int TC_W   = 9;
  localparam int VEC_W  = 8;

  // mode register bits
  localparam int MODE_W          = 6;
  localparam int MODE_TONE_IE    = 0;
  localparam int MODE_NS_IE      = 1;
  localparam int MODE_NSS        = 2;
  localparam int MODE_TIME_IE    = 3;
  localparam int MODE_NS_RATE_LO = 4;
  localparam int MODE_NS_RATE_HI = 5;

  typedef enum logic [2:0] {
    RANGE_00_07,
    RANGE_08_0F,
    RANGE_10_1F,
    RANGE_20_3F,
    RANGE_40_FF
  } tone_range_e;

  // lowest value wins
  typedef enum logic [1:0] {
    IRQ_TONE = 2'd0,
    IRQ_NS   = 2'd1,
    IRQ_TIME = 2'd2
  } irq_id_e;

  localparam logic [VEC_W-1:0] VEC_TONE_BASE = 8'h20;
  localparam logic [VEC_W-1:0] VEC_OFS_10_1F = 8'h04;
  localparam logic [VEC_W-1:0] VEC_OFS_20_3F = 8'h08;
  localparam logic [VEC_W-1:0] VEC_OFS_40_FF = 8'h0c;
  localparam logic [VEC_W-1:0] VEC_NS        = 8'h48;
  localparam logic [VEC_W-1:0] VEC_TIME      = 8'h80;

  localparam int TICK_DIV_DEF = 8;         // CLK per machine tick

endpackage

// ==== hw/psg_timebase.sv ====
////////////////////
// machine tick divider and free-running timer counter
// raises the time and NS events on falling counter bits
////////////////////

module psg_timebase #(
  parameter int TICK_DIV = psg_pkg::TICK_DIV_DEF
) (
  input  logic        CLK,
  input  logic        arst_n,
  psg_ctrl_if.user    ctrl,
  psg_evt_if.time_src evt
);

  localparam int DIV_W = $clog2(TICK_DIV);

  logic [DIV_W-1:0]         div_cnt;
  logic [psg_pkg::TC_W-1:0] tc;
  logic [psg_pkg::TC_W-1:0] tc_nxt;
  logic                     ns_bit_now;
  logic                     ns_bit_nxt;

  assign evt.tick = (div_cnt == DIV_W'(TICK_DIV - 1));
  assign tc_nxt   = tc + 1'b1;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      tc      <= '0;
    end else if (evt.tick) begin
      div_cnt <= '0;
      tc      <= tc_nxt;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // ns_rate picks the TC bit, slowest first
  always_comb begin
    case (ctrl.ns_rate)
      2'd0: begin ns_bit_now = tc[8]; ns_bit_nxt = tc_nxt[8]; end
      2'd1: begin ns_bit_now = tc[7]; ns_bit_nxt = tc_nxt[7]; end
      2'd2: begin ns_bit_now = tc[5]; ns_bit_nxt = tc_nxt[5]; end
      default: begin ns_bit_now = tc[4]; ns_bit_nxt = tc_nxt[4]; end
    endcase
  end

  // fall seen as the counter steps, so pulses sit in the tick cycle
  assign evt.time_evt = evt.tick & tc[psg_pkg::TC_W-1] & ~tc_nxt[psg_pkg::TC_W-1];
  assign evt.ns_evt   = evt.tick & ns_bit_now & ~ns_bit_nxt;

endmodule

// ==== hw/psg_tone_counter.sv ====
////////////////////
// N reload down-counter and tone event source
////////////////////

module psg_tone_counter (
  input  logic        CLK,
  input  logic        arst_n,
  psg_ctrl_if.user    ctrl,
  psg_evt_if.tone_src evt
);

  logic [psg_pkg::N_W-1:0] nc;         // down-counter
  logic [2:0]              nuc;        // reload count
  logic                    reload;
  logic                    reload_d;
  logic                    cond;
  logic                    cond_d;
  psg_pkg::tone_range_e    range;

  assign reload = (nc == psg_pkg::N_W'(1));

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      nc       <= '0;
      nuc      <= '0;
      reload_d <= 1'b0;
      cond_d   <= 1'b0;
    end else if (evt.tick) begin
      nc       <= reload ? ctrl.n_reload : nc - 1'b1;
      reload_d <= reload;
      if (reload_d)
        nuc <= nuc + 1'b1;
      cond_d   <= cond;
    end
  end

  ////////////////////
  // range of N decides which signal drives the tone
  always_comb begin
    if (ctrl.n_reload < 8'h08)      range = psg_pkg::RANGE_00_07;
    else if (ctrl.n_reload < 8'h10) range = psg_pkg::RANGE_08_0F;
    else if (ctrl.n_reload < 8'h20) range = psg_pkg::RANGE_10_1F;
    else if (ctrl.n_reload < 8'h40) range = psg_pkg::RANGE_20_3F;
    else                            range = psg_pkg::RANGE_40_FF;
  end

  always_comb begin
    case (range)
      psg_pkg::RANGE_08_0F: cond = nuc[2];
      psg_pkg::RANGE_10_1F: cond = nuc[1];
      psg_pkg::RANGE_20_3F: cond = nuc[0];
      psg_pkg::RANGE_40_FF: cond = reload_d;
      default:              cond = 1'b0;  // short N stays silent
    endcase
  end

  assign evt.tone_range = range;
  assign evt.tone_evt   = evt.tick & cond_d & ~cond;   // falling edge

  // counting and edge detection rely on one-CLK ticks from the timebase
  a_tick_single : assert property (
    @(posedge CLK) disable iff (!arst_n) evt.tick |=> !evt.tick
  );

endmodule

// ==== hw/psg_top.sv ====
////////////////////
// sound timer peripherals behind a host register port
////////////////////

module psg_top #(
  parameter int TICK_DIV = psg_pkg::TICK_DIV_DEF
) (
  input  logic                          CLK,
  input  logic                          arst_n,
  input  logic                          wr_req,
  input  logic [psg_pkg::WR_ADDR_W-1:0] wr_addr,
  input  logic [psg_pkg::WR_DATA_W-1:0] wr_data,
  output logic                          wr_ack,
  output logic                          int_req,
  input  logic                          int_ack,
  output logic [psg_pkg::VEC_W-1:0]     int_vec,
  output logic [psg_pkg::PCM_W-1:0]     pcm_out,
  output logic [psg_pkg::PNC1_W-1:0]    pnc_out,
  output logic                          noise_sign
);

  psg_ctrl_if ctrl_if ();
  psg_evt_if  evt_if ();

  psg_host_regs u_host_regs (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .wr_req  (wr_req),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_ack  (wr_ack),
    .ctrl    (ctrl_if.regs),
    .pcm_out (pcm_out)
  );

  psg_timebase #(
    .TICK_DIV (TICK_DIV)
  ) u_timebase (
    .CLK    (CLK),
    .arst_n (arst_n),
    .ctrl   (ctrl_if.user),
    .evt    (evt_if.time_src)
  );

  psg_tone_counter u_tone_counter (
    .CLK    (CLK),
    .arst_n (arst_n),
    .ctrl   (ctrl_if.user),
    .evt    (evt_if.tone_src)
  );

  psg_noise_lfsr u_noise_lfsr (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .ctrl       (ctrl_if.user),
    .ns_evt     (evt_if.ns_evt),
    .pnc_out    (pnc_out),
    .noise_sign (noise_sign)
  );

  psg_int_ctrl u_int_ctrl (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .ctrl    (ctrl_if.user),
    .evt     (evt_if.sink),
    .int_req (int_req),
    .int_ack (int_ack),
    .int_vec (int_vec)
  );

endmodule

// ==== tests/psg_checker.sv ====
////////////////////
// watches the DUT ports and compares them with reference models
////////////////////

module psg_checker (
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       wr_req,
  input  logic [1:0] wr_addr,
  input  logic [9:0] wr_data,
  input  logic       wr_ack,
  input  logic       int_req,
  input  logic       int_ack,
  input  logic [7:0] int_vec,
  input  logic [8:0] pcm_out,
  input  logic [6:0] pnc_out,
  input  logic       noise_sign,
  input  logic       tone_evt,
  input  logic       ns_evt,
  input  logic       time_evt,
  output int         errors
);

  logic [7:0] n_m;                     // host register mirrors
  logic [5:0] mode_m;
  logic [9:0] da_m;
  logic [2:0] pend;                    // pending model indexed by irq id
  logic [2:0] pend_q;
  logic [2:0] set_now;
  logic [2:0] act_mask;
  logic       wr_req_q;
  logic       wr_ack_q;
  logic       int_req_q;
  logic       int_ack_q;
  logic [6:0] pnc_q;
  logic [6:0] pnc_ref;
  logic [2:0] pnc2_ref;
  int         srv;
  int         chk_cnt   = 0;
  int         err_val   = 0;
  int         err_proto = 0;

  assign errors = err_val + err_proto;

  // sign flag followed by the sample or its complement
  function automatic logic [8:0] pcm_of_da(input logic [9:0] da);
    logic [7:0] smp;
    smp = da[9] ? 8'(255 - da[7:0]) : da[7:0];
    if (da[8])
      return {1'b1, 8'(255 - smp)};
    return {1'b0, smp};
  endfunction

  function automatic logic [6:0] pnc1_step(input logic [6:0] p);
    return {p[5:0], ~(p[5] ^ p[6])};
  endfunction

  function automatic logic [2:0] pnc2_step(input logic [2:0] p, input logic nss);
    if (nss)
      return {p[1:0], ~p[0]};
    return {p[1:0], ~p[1]};            // sign is 0 while nss is clear
  endfunction

  function automatic int tone_vec_of_n(input logic [7:0] n);
    if (n < 8'h08) return -1;          // no tone below 8
    if (n < 8'h10) return 'h20;
    if (n < 8'h20) return 'h24;
    if (n < 8'h40) return 'h28;
    return 'h2c;
  endfunction

  // irq id from the vector or -1 when unknown
  function automatic int src_of_vec(input logic [7:0] v, input logic [7:0] n);
    if (v == 8'h48) return 1;
    if (v == 8'h80) return 2;
    if (int'(v) == tone_vec_of_n(n)) return 0;
    return -1;
  endfunction

  task automatic report_counts();
    $display("checks %0d, value errors %0d, protocol errors %0d", chk_cnt, err_val, err_proto);
  endtask

  always @(posedge CLK) begin
    if (!arst_n) begin
      if (wr_ack || int_req || pcm_out != '0 || pnc_out != '0 || noise_sign) begin
        err_val++;
        $display("ERR %0t: outputs not cleared during reset", $time);
      end
      {n_m, mode_m, da_m} = '0;
      pend     = '0;
      pend_q   = '0;
      pnc_ref  = '0;
      pnc2_ref = '0;
    end else begin
      ////////////////////
      // write handshake and PCM
      if (wr_ack && !wr_ack_q && !wr_req_q) begin
        err_proto++;
        $display("protocol fault at %0t: wr_ack rose with no request", $time);
      end
      if (!wr_ack && wr_ack_q && wr_req_q) begin
        err_proto++;
        $display("protocol fault at %0t: wr_ack fell while wr_req was high", $time);
      end
      if (wr_ack && !wr_ack_q) begin
        chk_cnt++;
        if (pcm_out !== pcm_of_da(da_m)) begin
          err_val++;
          $display("ERR %0t: pcm_out %h, expected %h", $time, pcm_out, pcm_of_da(da_m));
        end
      end

      if (pnc_out != pnc_q) begin        // each new noise value
        pnc_ref = pnc1_step(pnc_ref);
        chk_cnt++;
        if (pnc_out !== pnc_ref) begin
          err_val++;
          $display("ERR %0t: pnc_out %h, expected %h", $time, pnc_out, pnc_ref);
        end
      end

      if (noise_sign !== (mode_m[2] & pnc2_ref[2])) begin
        err_val++;
        $display("ERR %0t: noise_sign %b, expected %b", $time, noise_sign,
                 mode_m[2] & pnc2_ref[2]);
      end
      if (ns_evt)                        // PNC2 steps with the nss seen here
        pnc2_ref = pnc2_step(pnc2_ref, mode_m[2]);

      ////////////////////
      // interrupts
      if (int_ack_q && int_req) begin
        err_proto++;
        $display("protocol fault at %0t: int_req high a clock after int_ack", $time);
      end
      act_mask = '0;
      srv      = -1;
      if (int_req) begin
        srv = src_of_vec(int_vec, n_m);
        if (srv >= 0)
          act_mask[srv] = 1'b1;
      end
      if (int_req && !int_req_q) begin
        chk_cnt++;
        if (srv < 0) begin
          err_val++;
          $display("ERR %0t: unexpected vector %h", $time, int_vec);
        end else if (!pend_q[srv]) begin
          err_val++;
          $display("ERR %0t: vector %h with source not pending (%b)", $time, int_vec, pend_q);
        end else if ((pend_q & ((3'b001 << srv) - 3'b001)) != '0) begin
          err_val++;
          $display("ERR %0t: served source %0d over pending %b", $time, srv, pend_q);
        end
        if (srv >= 0)
          pend[srv] = 1'b0;
      end
      pend_q  = pend;                  // grant looks one clock back
      set_now = {time_evt & mode_m[3], ns_evt & mode_m[1], tone_evt & mode_m[0]};
      pend    = pend | (set_now & ~act_mask);

      if (wr_req && !wr_ack) begin
        case (wr_addr)
          2'd0: n_m    = wr_data[7:0];
          2'd1: mode_m = wr_data[5:0];
          2'd2: da_m   = wr_data;
          default: ;
        endcase
      end
    end
    wr_req_q  = wr_req;
    wr_ack_q  = wr_ack;
    int_req_q = int_req;
    int_ack_q = int_ack;
    pnc_q     = pnc_out;
  end

endmodule

// ==== tests/psg_tb.sv ====
////////////////////
// testbench top with clock, reset, host writes and interrupt service
// drives psg_top through all runs while psg_checker compares
////////////////////

module psg_tb;

  localparam int TICK_DIV  = psg_pkg::TICK_DIV_DEF;
  localparam int TIME_T    = 512;     // ticks per time event
  localparam int NS_T      = 32;      // ticks per NS event at rate 3
  localparam int ACK_DLY   = 40;      // late ack in the priority run, ticks
  localparam int MARGIN    = 64;      // ticks of slack per run
  localparam int NUM_PCM   = 40;
  localparam int NUM_NOISE = 16;
  localparam int NUM_PRIO  = 20;

  // pcm, time, four tone ranges, silent tone, noise, priority
  localparam longint WD_TICKS = MARGIN + (2 * TIME_T + MARGIN) + 4 * (TIME_T + MARGIN)
                              + (2 * TIME_T + MARGIN) + (NUM_NOISE * NS_T + MARGIN)
                              + (NUM_PRIO * (ACK_DLY + NS_T) + MARGIN);
  localparam longint WD_TIME  = WD_TICKS * TICK_DIV * 10 + 16 * 10;

  localparam logic [7:0] TONE_N [4] = '{8'h0c, 8'h18, 8'h30, 8'h80};

  logic        CLK;
  logic        arst_n;
  logic        wr_req;
  logic [1:0]  wr_addr;
  logic [9:0]  wr_data;
  logic        wr_ack;
  logic        int_req;
  logic        int_ack;
  logic [7:0]  int_vec;
  logic [8:0]  pcm_out;
  logic [6:0]  pnc_out;
  logic        noise_sign;
  logic [31:0] rng;
  int          errors;

  psg_top #(
    .TICK_DIV (TICK_DIV)
  ) u_psg_top (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_ack     (wr_ack),
    .int_req    (int_req),
    .int_ack    (int_ack),
    .int_vec    (int_vec),
    .pcm_out    (pcm_out),
    .pnc_out    (pnc_out),
    .noise_sign (noise_sign)
  );

  psg_checker u_checker (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_ack     (wr_ack),
    .int_req    (int_req),
    .int_ack    (int_ack),
    .int_vec    (int_vec),
    .pcm_out    (pcm_out),
    .pnc_out    (pnc_out),
    .noise_sign (noise_sign),
    .tone_evt   (u_psg_top.evt_if.tone_evt),  // event taps for the pending model
    .ns_evt     (u_psg_top.evt_if.ns_evt),
    .time_evt   (u_psg_top.evt_if.time_evt),
    .errors     (errors)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      rng = lfsr_next(rng);
      val = {val[30:0], rng[0]};
    end
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    arst_n  <= 1'b0;
    wr_req  <= 1'b0;
    int_ack <= 1'b0;
    repeat (16) @(posedge CLK);
    arst_n <= 1'b1;
  endtask

  // four-phase write that returns once wr_ack has dropped again
  task automatic host_write(input logic [1:0] addr, input logic [9:0] data);
    @(posedge CLK);
    wr_addr <= addr;
    wr_data <= data;
    wr_req  <= 1'b1;
    do @(posedge CLK); while (!wr_ack);
    wr_req <= 1'b0;
    do @(posedge CLK); while (wr_ack);
  endtask

  // wait for a request, hold off dly clocks, then acknowledge
  task automatic serve_irq(input int dly);
    do @(posedge CLK); while (!int_req);
    repeat (dly) @(posedge CLK);
    int_ack <= 1'b1;
    do @(posedge CLK); while (int_req);
    int_ack <= 1'b0;
  endtask

  ////////////////////
  // test sequence
  initial begin : stimulus
    logic [31:0] rv;
    arst_n  = 1'b0;
    wr_req  = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    int_ack = 1'b0;
    rng     = 32'hd7f4e414;
    repeat (16) @(posedge CLK);
    arst_n <= 1'b1;

    // random DA samples and one write to the unused address
    for (int i = 0; i < NUM_PCM; i++) begin
      rand_bits(10, rv);
      host_write(psg_pkg::ADDR_DA, rv[9:0]);
    end
    host_write(2'd3, 10'h3ff);

    // time source only
    host_write(psg_pkg::ADDR_MODE, 10'(1 << psg_pkg::MODE_TIME_IE));
    repeat (2) serve_irq(2);

    // tone vectors for each range
    for (int i = 0; i < 4; i++) begin
      apply_reset();
      host_write(psg_pkg::ADDR_N, {2'b00, TONE_N[i]});
      host_write(psg_pkg::ADDR_MODE, 10'(1 << psg_pkg::MODE_TONE_IE));
      serve_irq(2);
    end

    // N below 8 stays silent for two time periods
    apply_reset();
    host_write(psg_pkg::ADDR_N, 10'h005);
    host_write(psg_pkg::ADDR_MODE, 10'(1 << psg_pkg::MODE_TONE_IE));
    repeat (2 * TIME_T * TICK_DIV) @(posedge CLK);

    // noise at rate 3 with nss
    apply_reset();
    host_write(psg_pkg::ADDR_MODE, 10'((1 << psg_pkg::MODE_NS_IE) | (1 << psg_pkg::MODE_NSS)
                                       | (3 << psg_pkg::MODE_NS_RATE_LO)));
    repeat (NUM_NOISE) serve_irq(2);

    // all sources with late acks so events pile up
    apply_reset();
    host_write(psg_pkg::ADDR_N, 10'h080);
    host_write(psg_pkg::ADDR_MODE, 10'((1 << psg_pkg::MODE_TONE_IE) | (1 << psg_pkg::MODE_NS_IE)
                                       | (1 << psg_pkg::MODE_TIME_IE)
                                       | (3 << psg_pkg::MODE_NS_RATE_LO)));
    repeat (NUM_PRIO) serve_irq(ACK_DLY * TICK_DIV);

    repeat (4) @(posedge CLK);
    u_checker.report_counts();
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WD_TIME);
    $display("timeout: the DUT stopped answering a handshake or an interrupt never came");
    u_checker.report_counts();
    $display("sim failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/psg_pkg.sv
hw/psg_ifs.sv
hw/psg_host_regs.sv
hw/psg_timebase.sv
hw/psg_tone_counter.sv
hw/psg_noise_lfsr.sv
hw/psg_int_ctrl.sv
hw/psg_top.sv
tests/psg_checker.sv
tests/psg_tb.sv
